// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rx_frontend_tb
FILELIST  ?= rx_frontend.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: include/rx_frontend_macros.svh
// ********************
// RX frontend constants
// Channel count, bus widths and register map
// ********************
`ifndef RX_FRONTEND_MACROS_SVH
`define RX_FRONTEND_MACROS_SVH

// Channel count and bus widths
`define RX_NUM_CHAN    4
`define RX_ADDR_W      12
`define RX_DATA_W      32
`define RX_SAMPLE_W    16
`define RX_WIDE_W      24
`define RX_CORR_W      18
`define RX_MAP_W       8

// Per-channel registers repeat every stride
`define RX_CHAN_STRIDE 'h20
`define RX_REG_MAP     5'h00
`define RX_REG_MAG     5'h04
`define RX_REG_PHASE   5'h08
`define RX_REG_OFS_I   5'h0c
`define RX_REG_OFS_Q   5'h10

// Sticky overflow status, write one to clear
`define RX_REG_OVF     12'h100

// Bits of the map register
`define RX_MAP_SWAP    0
`define RX_MAP_REAL    1
`define RX_MAP_INV_Q   2
`define RX_MAP_INV_I   3
`define RX_MAP_BYPASS  7

`endif

// File: logic/rx_chan_merge.sv
// ********************
// RX channel merge
// Round-robin drain of per-channel slots into one stream
// ********************
`include "rx_frontend_macros.svh"

module rx_chan_merge
  import rx_frontend_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`RX_NUM_CHAN-1:0] in_stb_i,
  input  sample_t                 in_i_i [`RX_NUM_CHAN],
  input  sample_t                 in_q_i [`RX_NUM_CHAN],
  input  logic                    rx_ready_i,
  output logic                    rx_valid_o,
  output chan_idx_t               rx_chan_o,
  output sample_t                 rx_i_o,
  output sample_t                 rx_q_o,
  output logic [`RX_NUM_CHAN-1:0] ovf_set_o
);

  logic [`RX_NUM_CHAN-1:0] full_q;
  sample_t                 slot_i_q [`RX_NUM_CHAN];
  sample_t                 slot_q_q [`RX_NUM_CHAN];
  chan_idx_t               last_q;
  chan_idx_t               pick_idx;
  logic                    pick_valid;
  logic                    load;

  // Nearest full slot after the last one served
  always_comb begin
    int cand;
    pick_valid = 1'b0;
    pick_idx   = last_q;
    for (int k = `RX_NUM_CHAN; k >= 1; k--) begin
      cand = (int'(last_q) + k) % `RX_NUM_CHAN;
      if (full_q[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = chan_idx_t'(cand);
      end
    end
  end

  assign load      = pick_valid & (~rx_valid_o | rx_ready_i);
  // A strobe into a full slot loses its sample
  assign ovf_set_o = in_stb_i & full_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= '0;
    end else begin
      for (int c = 0; c < `RX_NUM_CHAN; c++) begin
        if (in_stb_i[c] && !full_q[c]) begin
          full_q[c] <= 1'b1;
        end else if (load && pick_idx == chan_idx_t'(c)) begin
          full_q[c] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < `RX_NUM_CHAN; c++) begin
      if (in_stb_i[c] && !full_q[c]) begin
        slot_i_q[c] <= in_i_i[c];
        slot_q_q[c] <= in_q_i[c];
      end
    end
  end

  // Output register, channel 0 goes first after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_valid_o <= 1'b0;
      last_q     <= chan_idx_t'(`RX_NUM_CHAN - 1);
    end else if (load) begin
      rx_valid_o <= 1'b1;
      last_q     <= pick_idx;
    end else if (rx_ready_i) begin
      rx_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rx_chan_o <= pick_idx;
      rx_i_o    <= slot_i_q[pick_idx];
      rx_q_o    <= slot_q_q[pick_idx];
    end
  end

endmodule

// File: logic/rx_frontend_chan.sv
// ********************
// RX channel frontend
// IQ mapping, DC offset, IQ compensation and rounding
// ********************
`include "rx_frontend_macros.svh"

module rx_frontend_chan
  import rx_frontend_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 adc_stb_i,
  input  sample_t              adc_i_i,
  input  sample_t              adc_q_i,
  input  logic [`RX_MAP_W-1:0] map_i,
  input  corr_t                mag_i,
  input  corr_t                phase_i,
  input  wide_t                ofs_i_i,
  input  wide_t                ofs_q_i,
  output logic                 out_stb_o,
  output sample_t              out_i_o,
  output sample_t              out_q_o
);

  localparam int STAGES = 5;
  localparam int LOW_W  = `RX_WIDE_W - `RX_SAMPLE_W;
  localparam int PROD_W = 2 * `RX_CORR_W;
  localparam logic [`RX_WIDE_W:0] ROUND_HALF = 1 << (LOW_W - 1);

  logic [STAGES-1:0]        stb_q;
  sample_t                  sel_i;
  sample_t                  sel_q;
  // Raw pair and bypass flag follow the datapath
  sample_t                  raw_i_q [STAGES-1];
  sample_t                  raw_q_q [STAGES-1];
  logic [STAGES-2:0]        byp_q;
  wide_t                    mix_i_q;
  wide_t                    mix_q_q;
  wide_t                    ofs_i_q;
  wide_t                    ofs_q_q;
  logic signed [PROD_W-1:0] prod_i_q;
  logic signed [PROD_W-1:0] prod_q_q;
  wide_t                    dly_i_q;
  wide_t                    dly_q_q;
  wide_t                    comp_i_q;
  wide_t                    comp_q_q;

  // Clip a sign-extended sum back to the internal width
  function automatic wide_t sat_wide(input logic [`RX_WIDE_W:0] s);
    if (s[`RX_WIDE_W] != s[`RX_WIDE_W-1]) begin
      return s[`RX_WIDE_W] ? WIDE_MIN : WIDE_MAX;
    end
    return s[`RX_WIDE_W-1:0];
  endfunction

  // Round half up and drop the guard bits
  function automatic sample_t round_sample(input wide_t x);
    logic [`RX_WIDE_W:0]   s;
    logic [`RX_SAMPLE_W:0] t;
    s = {x[`RX_WIDE_W-1], x} + ROUND_HALF;
    t = s[`RX_WIDE_W:LOW_W];
    if (t[`RX_SAMPLE_W] != t[`RX_SAMPLE_W-1]) begin
      return t[`RX_SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
    end
    return t[`RX_SAMPLE_W-1:0];
  endfunction

  // Swap picks the source, inversion applies to the picked input
  always_comb begin
    if (map_i[`RX_MAP_SWAP]) begin
      sel_i = map_i[`RX_MAP_INV_Q] ? ~adc_q_i : adc_q_i;
      sel_q = map_i[`RX_MAP_INV_I] ? ~adc_i_i : adc_i_i;
    end else begin
      sel_i = map_i[`RX_MAP_INV_I] ? ~adc_i_i : adc_i_i;
      sel_q = map_i[`RX_MAP_INV_Q] ? ~adc_q_i : adc_q_i;
    end
    if (map_i[`RX_MAP_REAL]) begin
      sel_q = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_q <= '0;
    end else begin
      stb_q <= {stb_q[STAGES-2:0], adc_stb_i};
    end
  end

  assign out_stb_o = stb_q[STAGES-1];

  always_ff @(posedge clk) begin
    // Stage 1, mapping into the upper bits
    if (adc_stb_i) begin
      mix_i_q    <= {sel_i, {LOW_W{1'b0}}};
      mix_q_q    <= {sel_q, {LOW_W{1'b0}}};
      raw_i_q[0] <= adc_i_i;
      raw_q_q[0] <= adc_q_i;
      byp_q[0]   <= map_i[`RX_MAP_BYPASS];
    end
    for (int s = 1; s < STAGES - 1; s++) begin
      if (stb_q[s-1]) begin
        raw_i_q[s] <= raw_i_q[s-1];
        raw_q_q[s] <= raw_q_q[s-1];
        byp_q[s]   <= byp_q[s-1];
      end
    end
    // Stage 2, DC offset removal
    if (stb_q[0]) begin
      ofs_i_q <= sat_wide({mix_i_q[`RX_WIDE_W-1], mix_i_q} - {ofs_i_i[`RX_WIDE_W-1], ofs_i_i});
      ofs_q_q <= sat_wide({mix_q_q[`RX_WIDE_W-1], mix_q_q} - {ofs_q_i[`RX_WIDE_W-1], ofs_q_i});
    end
    // Stage 3, both corrections are driven from I
    if (stb_q[1]) begin
      prod_i_q <= $signed(ofs_i_q[`RX_WIDE_W-1 -: `RX_CORR_W]) * mag_i;
      prod_q_q <= $signed(ofs_i_q[`RX_WIDE_W-1 -: `RX_CORR_W]) * phase_i;
      dly_i_q  <= ofs_i_q;
      dly_q_q  <= ofs_q_q;
    end
    // Stage 4, add the scaled products
    if (stb_q[2]) begin
      comp_i_q <= sat_wide({dly_i_q[`RX_WIDE_W-1], dly_i_q} +
                           {prod_i_q[PROD_W-1], prod_i_q[PROD_W-1 -: `RX_WIDE_W]});
      comp_q_q <= sat_wide({dly_q_q[`RX_WIDE_W-1], dly_q_q} +
                           {prod_q_q[PROD_W-1], prod_q_q[PROD_W-1 -: `RX_WIDE_W]});
    end
    // Stage 5, rounding or raw bypass
    if (stb_q[3]) begin
      out_i_o <= byp_q[STAGES-2] ? raw_i_q[STAGES-2] : round_sample(comp_i_q);
      out_q_o <= byp_q[STAGES-2] ? raw_q_q[STAGES-2] : round_sample(comp_q_q);
    end
  end

endmodule

// File: logic/rx_frontend_pkg.sv
// ********************
// RX frontend types
// Sample, correction and channel index types
// ********************
`include "rx_frontend_macros.svh"

package rx_frontend_pkg;

  // ADC input and stream output sample
  typedef logic signed [`RX_SAMPLE_W-1:0] sample_t;

  // Internal sample with fractional guard bits
  typedef logic signed [`RX_WIDE_W-1:0] wide_t;

  // Magnitude and phase correction coefficient
  typedef logic signed [`RX_CORR_W-1:0] corr_t;

  // Channel number, at least one bit wide
  localparam int CHAN_IDX_W = (`RX_NUM_CHAN > 1) ? $clog2(`RX_NUM_CHAN) : 1;
  typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

  // Saturation limits
  localparam sample_t SAMPLE_MAX = {1'b0, {(`RX_SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(`RX_SAMPLE_W-1){1'b0}}};
  localparam wide_t   WIDE_MAX   = {1'b0, {(`RX_WIDE_W-1){1'b1}}};
  localparam wide_t   WIDE_MIN   = {1'b1, {(`RX_WIDE_W-1){1'b0}}};

endpackage

// File: logic/rx_frontend_regs.sv
// ********************
// RX frontend APB registers
// Per-channel correction settings and sticky overflow status
// ********************
`include "rx_frontend_macros.svh"

module rx_frontend_regs
  import rx_frontend_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // APB slave
  input  logic [`RX_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`RX_DATA_W-1:0] pwdata_i,
  output logic [`RX_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // Overflow events from the merge block
  input  logic [`RX_NUM_CHAN-1:0] ovf_set_i,
  // Settings to the channels
  output logic [`RX_MAP_W-1:0]  map_o   [`RX_NUM_CHAN],
  output corr_t                 mag_o   [`RX_NUM_CHAN],
  output corr_t                 phase_o [`RX_NUM_CHAN],
  output wide_t                 ofs_i_o [`RX_NUM_CHAN],
  output wide_t                 ofs_q_o [`RX_NUM_CHAN]
);

  localparam int OFS_W   = $clog2(`RX_CHAN_STRIDE);
  localparam int FIELD_W = `RX_ADDR_W - OFS_W;
  localparam logic [FIELD_W-1:0] NUM_CHAN_F = FIELD_W'(`RX_NUM_CHAN);

  logic [FIELD_W-1:0]      chan_field;
  logic [OFS_W-1:0]        reg_ofs;
  chan_idx_t               sel;
  logic                    chan_hit;
  logic                    ovf_hit;
  logic                    reg_hit;
  logic                    access;
  logic                    wr_en;
  logic [`RX_DATA_W-1:0]   rd_data;
  logic [`RX_NUM_CHAN-1:0] ovf_q;
  logic [`RX_NUM_CHAN-1:0] ovf_clr;

  // Split the address into channel block and register offset
  assign chan_field = paddr_i[`RX_ADDR_W-1:OFS_W];
  assign reg_ofs    = paddr_i[OFS_W-1:0];
  assign sel        = chan_idx_t'(chan_field);
  assign ovf_hit    = (paddr_i == `RX_REG_OVF);

  always_comb begin
    chan_hit = 1'b0;
    rd_data  = '0;
    if (chan_field < NUM_CHAN_F) begin
      chan_hit = 1'b1;
      case (reg_ofs)
        `RX_REG_MAP:   rd_data[`RX_MAP_W-1:0]  = map_o[sel];
        `RX_REG_MAG:   rd_data[`RX_CORR_W-1:0] = mag_o[sel];
        `RX_REG_PHASE: rd_data[`RX_CORR_W-1:0] = phase_o[sel];
        `RX_REG_OFS_I: rd_data[`RX_WIDE_W-1:0] = ofs_i_o[sel];
        `RX_REG_OFS_Q: rd_data[`RX_WIDE_W-1:0] = ofs_q_o[sel];
        default:       chan_hit = 1'b0;
      endcase
    end else if (ovf_hit) begin
      rd_data[`RX_NUM_CHAN-1:0] = ovf_q;
    end
  end

  assign reg_hit   = chan_hit | ovf_hit;
  assign access    = psel_i & penable_i;
  assign wr_en     = access & pwrite_i & reg_hit;

  // Zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~reg_hit;
  assign prdata_o  = rd_data;

  // Channel settings
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < `RX_NUM_CHAN; c++) begin
        map_o[c]   <= '0;
        mag_o[c]   <= '0;
        phase_o[c] <= '0;
        ofs_i_o[c] <= '0;
        ofs_q_o[c] <= '0;
      end
    end else if (wr_en && chan_hit) begin
      case (reg_ofs)
        `RX_REG_MAP:   map_o[sel]   <= pwdata_i[`RX_MAP_W-1:0];
        `RX_REG_MAG:   mag_o[sel]   <= pwdata_i[`RX_CORR_W-1:0];
        `RX_REG_PHASE: phase_o[sel] <= pwdata_i[`RX_CORR_W-1:0];
        `RX_REG_OFS_I: ofs_i_o[sel] <= pwdata_i[`RX_WIDE_W-1:0];
        `RX_REG_OFS_Q: ofs_q_o[sel] <= pwdata_i[`RX_WIDE_W-1:0];
        default:       ;
      endcase
    end
  end

  // Sticky overflow, a new event beats a clear in the same cycle
  assign ovf_clr = (wr_en && ovf_hit) ? pwdata_i[`RX_NUM_CHAN-1:0] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      ovf_q <= '0;
    end else begin
      ovf_q <= (ovf_q & ~ovf_clr) | ovf_set_i;
    end
  end

endmodule

// File: logic/rx_frontend_top.sv
// ********************
// RX frontend top level
// Registers, channel frontends and merge block
// ********************
`include "rx_frontend_macros.svh"

module rx_frontend_top
  import rx_frontend_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  // APB register access
  input  logic [`RX_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [`RX_DATA_W-1:0] pwdata_i,
  output logic [`RX_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // ADC samples, one strobe for all channels
  input  logic                  adc_stb_i,
  input  sample_t               adc_i_i [`RX_NUM_CHAN],
  input  sample_t               adc_q_i [`RX_NUM_CHAN],
  // Merged output stream
  input  logic                  rx_ready_i,
  output logic                  rx_valid_o,
  output chan_idx_t             rx_chan_o,
  output sample_t               rx_i_o,
  output sample_t               rx_q_o
);

  logic [`RX_MAP_W-1:0]    map   [`RX_NUM_CHAN];
  corr_t                   mag   [`RX_NUM_CHAN];
  corr_t                   phase [`RX_NUM_CHAN];
  wide_t                   ofs_i [`RX_NUM_CHAN];
  wide_t                   ofs_q [`RX_NUM_CHAN];
  logic [`RX_NUM_CHAN-1:0] chan_stb;
  sample_t                 chan_i [`RX_NUM_CHAN];
  sample_t                 chan_q [`RX_NUM_CHAN];
  logic [`RX_NUM_CHAN-1:0] ovf_set;

  rx_frontend_regs i_regs (
    .clk       (clk),
    .reset     (reset),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .ovf_set_i (ovf_set),
    .map_o     (map),
    .mag_o     (mag),
    .phase_o   (phase),
    .ofs_i_o   (ofs_i),
    .ofs_q_o   (ofs_q)
  );

  for (genvar g = 0; g < `RX_NUM_CHAN; g++) begin : gen_chan
    rx_frontend_chan i_chan (
      .clk       (clk),
      .reset     (reset),
      .adc_stb_i (adc_stb_i),
      .adc_i_i   (adc_i_i[g]),
      .adc_q_i   (adc_q_i[g]),
      .map_i     (map[g]),
      .mag_i     (mag[g]),
      .phase_i   (phase[g]),
      .ofs_i_i   (ofs_i[g]),
      .ofs_q_i   (ofs_q[g]),
      .out_stb_o (chan_stb[g]),
      .out_i_o   (chan_i[g]),
      .out_q_o   (chan_q[g])
    );
  end

  rx_chan_merge i_merge (
    .clk        (clk),
    .reset      (reset),
    .in_stb_i   (chan_stb),
    .in_i_i     (chan_i),
    .in_q_i     (chan_q),
    .rx_ready_i (rx_ready_i),
    .rx_valid_o (rx_valid_o),
    .rx_chan_o  (rx_chan_o),
    .rx_i_o     (rx_i_o),
    .rx_q_o     (rx_q_o),
    .ovf_set_o  (ovf_set)
  );

endmodule

// File: rx_frontend.f
+incdir+include
logic/rx_frontend_pkg.sv
logic/rx_frontend_regs.sv
logic/rx_frontend_chan.sv
logic/rx_chan_merge.sv
logic/rx_frontend_top.sv
tests/rx_frontend_tb.sv

// File: tests/rx_frontend_stim.txt
# W addr data | S i0 q0 i1 q1 i2 q2 i3 q3 | E chan exp_i exp_q
# All values in hex
W 004 FFFFFFFF
W 028 12345678
W 04C ABCDEF01
W 070 FFFFFFFF
W 060 FFFFFFFF
W 004 0
W 028 0
W 04C 0
W 070 0
W 060 0
# Mapping: swap, invert both, real mode, bypass
W 000 1
W 020 C
W 040 2
W 060 80
S 1234 5678 1234 8000 4321 1111 ABCD 0123
E 0 5678 1234
E 1 EDCB 7FFF
E 2 4321 0000
E 3 ABCD 0123
# DC offset with saturation at both ends
W 000 0
W 020 0
W 040 0
W 060 0
W 00C 100
W 010 80
W 02C 800000
W 030 1
W 04C FFFF00
S 1000 1000 7FFF 8000 0005 FFFF 0001 0002
E 0 0FFF 1000
E 1 7FFF 8000
E 2 0006 FFFF
E 3 0001 0002
# IQ compensation and output saturation
W 00C 0
W 010 0
W 02C 0
W 030 0
W 04C 0
W 004 10000
W 008 8000
W 024 1FFFF
W 044 1FFFF
W 064 3FC00
W 068 200
S 1000 0200 7FFF 0010 8000 0000 0100 0003
E 0 1400 0400
E 1 7FFF 0010
E 2 8000 0000
E 3 00FF 0004
# Merge with all settings back at zero
W 004 0
W 008 0
W 024 0
W 044 0
W 064 0
W 068 0
S 0011 0012 0021 0022 0031 0032 0041 0042
E 0 0011 0012
E 1 0021 0022
E 2 0031 0032
E 3 0041 0042
S 7001 8002 6003 9004 5005 A006 4007 B008
E 0 7001 8002
E 1 6003 9004
E 2 5005 A006
E 3 4007 B008

// File: tests/rx_frontend_tb.sv
// ********************
// RX frontend testbench
// File driven APB, ADC and stream checks
// ********************
`include "rx_frontend_macros.svh"

module rx_frontend_tb
  import rx_frontend_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    TIMEOUT   = 500;
  localparam string STIM_FILE = "tests/rx_frontend_stim.txt";

  logic                  clk;
  logic                  reset;
  logic [`RX_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`RX_DATA_W-1:0] pwdata;
  logic [`RX_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  adc_stb;
  sample_t               adc_i [`RX_NUM_CHAN];
  sample_t               adc_q [`RX_NUM_CHAN];
  logic                  rx_ready;
  logic                  rx_valid;
  chan_idx_t             rx_chan;
  sample_t               rx_i;
  sample_t               rx_q;
  // Expected {I, Q} per channel, in arrival order
  logic [31:0]           exp_q [`RX_NUM_CHAN][$];
  logic                  rand_ready_en;
  logic                  check_en;

  rx_frontend_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr),
    .adc_stb_i  (adc_stb),
    .adc_i_i    (adc_i),
    .adc_q_i    (adc_q),
    .rx_ready_i (rx_ready),
    .rx_valid_o (rx_valid),
    .rx_chan_o  (rx_chan),
    .rx_i_o     (rx_i),
    .rx_q_o     (rx_q)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
      fail_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  // Implemented bits of each per-channel register
  function automatic logic [31:0] field_mask(input logic [`RX_ADDR_W-1:0] addr);
    case (addr[4:0])
      5'h00:        return (32'd1 << `RX_MAP_W) - 1;
      5'h04, 5'h08: return (32'd1 << `RX_CORR_W) - 1;
      5'h0c, 5'h10: return (32'd1 << `RX_WIDE_W) - 1;
      default:      return '0;
    endcase
  endfunction

  function automatic bit stream_idle();
    for (int c = 0; c < `RX_NUM_CHAN; c++) begin
      if (exp_q[c].size() != 0) begin
        return 1'b0;
      end
    end
    return !rx_valid;
  endfunction

  task automatic wait_drained();
    int count;
    count = 0;
    while (!stream_idle()) begin
      @(negedge clk);
      count++;
      if (count > TIMEOUT) begin
        fail_run("Timeout waiting for the output stream to drain");
      end
    end
  endtask

  // Access phase completes when pready is seen high
  task automatic finish_access(output logic [31:0] data, output logic err);
    int count;
    count = 0;
    @(negedge clk);
    while (!pready) begin
      count++;
      if (count > TIMEOUT) begin
        fail_run("Timeout waiting for pready on the APB");
      end
      @(negedge clk);
    end
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_access(input logic [`RX_ADDR_W-1:0] addr, input logic wr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwdata  <= wdata;
    pwrite  <= wr;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    finish_access(rdata, err);
  endtask

  task automatic write_and_verify(input logic [`RX_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    wait_drained();
    apb_access(addr, 1'b1, data, rd, err);
    if (err) begin
      fail_run($sformatf("Slave error on write to address 0x%h", addr));
    end
    if (addr != `RX_REG_OVF) begin
      apb_access(addr, 1'b0, '0, rd, err);
      if (err) begin
        fail_run($sformatf("Slave error on read of address 0x%h", addr));
      end
      check_reg("prdata_o", data & field_mask(addr), rd);
    end
  endtask

  task automatic check_unmapped(input logic [`RX_ADDR_W-1:0] addr);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, 1'b0, '0, rd, err);
    if (!err) begin
      fail_run($sformatf("No slave error on read of unmapped address 0x%h", addr));
    end
  endtask

  task automatic drive_samples(input logic [15:0] v [8]);
    @(posedge clk);
    adc_stb <= 1'b1;
    for (int c = 0; c < `RX_NUM_CHAN; c++) begin
      adc_i[c] <= v[2*c];
      adc_q[c] <= v[2*c+1];
    end
    @(posedge clk);
    adc_stb <= 1'b0;
  endtask

  task automatic run_stim_file();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] ch;
    logic [15:0] ei;
    logic [15:0] eq;
    logic [15:0] v [8];
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_run("Cannot open the stimulus file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        kind = line[0];
        case (kind)
          "W": begin
            n = $sscanf(line, "W %h %h", addr, data);
            if (n != 2) begin
              fail_run("Malformed register write record in the stimulus file");
            end
            write_and_verify(addr[`RX_ADDR_W-1:0], data);
          end
          "S": begin
            n = $sscanf(line, "S %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
            if (n != 8) begin
              fail_run("Malformed sample record in the stimulus file");
            end
            wait_drained();
            drive_samples(v);
          end
          "E": begin
            n = $sscanf(line, "E %h %h %h", ch, ei, eq);
            if (n != 3 || ch >= `RX_NUM_CHAN) begin
              fail_run("Malformed expected result record in the stimulus file");
            end
            exp_q[int'(ch)].push_back({ei, eq});
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Slots stay full while the sink stalls, so later strobes are lost
  task automatic check_overflow();
    logic [31:0] rd;
    logic        err;
    logic [15:0] z [8];
    int          count;
    for (int k = 0; k < 8; k++) begin
      z[k] = '0;
    end
    wait_drained();
    check_en      <= 1'b0;
    rand_ready_en <= 1'b0;
    repeat (3) begin
      drive_samples(z);
      repeat (2) @(posedge clk);
    end
    count = 0;
    rd    = '0;
    while (rd[`RX_NUM_CHAN-1:0] != '1) begin
      count++;
      if (count > 50) begin
        fail_run("Overflow bits did not set for every channel");
      end
      apb_access(`RX_REG_OVF, 1'b0, '0, rd, err);
      if (err) begin
        fail_run("Slave error on read of the overflow status");
      end
    end
    check_reg("prdata_o", (32'd1 << `RX_NUM_CHAN) - 1, rd);
    apb_access(`RX_REG_OVF, 1'b1, (32'd1 << `RX_NUM_CHAN) - 1, rd, err);
    if (err) begin
      fail_run("Slave error on write of the overflow status");
    end
    apb_access(`RX_REG_OVF, 1'b0, '0, rd, err);
    if (err) begin
      fail_run("Slave error on read of the overflow status");
    end
    check_reg("prdata_o", 32'h0, rd);
  endtask

  // Sink with random stalls
  initial begin
    forever begin
      @(posedge clk);
      rx_ready <= rand_ready_en ? ($urandom_range(3) != 0) : 1'b0;
    end
  end

  // A transfer seen at the falling edge completes on the next rising edge
  initial begin
    logic [31:0] exp;
    forever begin
      @(negedge clk);
      if (check_en && rx_valid && rx_ready) begin
        if (exp_q[rx_chan].size() == 0) begin
          fail_run($sformatf("Unexpected output sample on channel %0d", rx_chan));
        end
        exp = exp_q[rx_chan].pop_front();
        check_sample("rx_i_o", exp[31:16], rx_i);
        check_sample("rx_q_o", exp[15:0], rx_q);
      end
    end
  end

  initial begin
    void'($urandom(32'hc463_0bd0));
    reset         = 1'b1;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    pwdata        = '0;
    adc_stb       = 1'b0;
    rx_ready      = 1'b0;
    rand_ready_en = 1'b0;
    check_en      = 1'b1;
    for (int c = 0; c < `RX_NUM_CHAN; c++) begin
      adc_i[c] = '0;
      adc_q[c] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_unmapped(12'h014);
    check_unmapped(12'h080);
    check_unmapped(12'h104);
    rand_ready_en <= 1'b1;
    run_stim_file();
    wait_drained();
    check_overflow();
    $display("TEST PASS");
    $finish;
  end

endmodule
